//--- hdl/rv_pkg.sv
/* Shared types and constants for the RV32I subsystem: instruction formats,
   opcodes, ALU functions, Wishbone structs and the memory map */
package rv_pkg;

   // RAM size and boot vectors
   localparam int unsigned MEM_WORDS   = 1024;
   localparam int unsigned MEM_AW      = $clog2(MEM_WORDS);
   localparam logic [15:0] VEC_RESET   = 16'h0080;
   localparam logic [15:0] VEC_SP      = 16'h0084;
   localparam logic [4:0]  SP_INIT_REG = 5'd2;

   // Host side register map
   localparam logic [15:0] HOST_CTRL_BASE = 16'h8000;
   localparam logic [15:0] REG_CTRL       = 16'h0000;
   localparam logic [15:0] REG_STATUS     = 16'h0004;
   localparam logic [15:0] REG_RETIRED    = 16'h0008;

   typedef enum logic [6:0] {
      ALU_R  = 7'b0110011,
      ALU_I  = 7'b0010011,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      BRANCH = 7'b1100011,
      JAL    = 7'b1101111,
      JALR   = 7'b1100111,
      LUI    = 7'b0110111,
      AUIPC  = 7'b0010111
   } opcode_e;

   // funct7[5] then funct3, EQ takes an unused slot
   typedef enum logic [3:0] {
      ADD  = 4'b0000,
      SLL  = 4'b0001,
      SLT  = 4'b0010,
      SLTU = 4'b0011,
      XOR  = 4'b0100,
      SRL  = 4'b0101,
      OR   = 4'b0110,
      AND  = 4'b0111,
      SUB  = 4'b1000,
      EQ   = 4'b1001,
      SRA  = 4'b1101
   } alu_fn_e;

   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
      struct packed {
         logic [6:0] imm_11_5;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm_4_0;
         logic [6:0] opcode;
      } s;
      struct packed {
         logic       imm_12;
         logic [5:0] imm_10_5;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [3:0] imm_4_1;
         logic       imm_11;
         logic [6:0] opcode;
      } b;
      struct packed {
         logic [19:0] imm_31_12;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } u;
      struct packed {
         logic       imm_20;
         logic [9:0] imm_10_1;
         logic       imm_11;
         logic [7:0] imm_19_12;
         logic [4:0] rd;
         logic [6:0] opcode;
      } j;
   } inst_u;

   typedef struct packed {
      opcode_e     opcode;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [2:0]  funct3;
      logic [31:0] imm;
      alu_fn_e     alu_fn;
      logic        sel_pc;
      logic        sel_imm;
      logic        legal;
   } dec_t;

   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [15:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

endpackage

//--- hdl/rv_alu.sv
/* Combinational ALU of the core, also supplies the equality flag
   used for BEQ and BNE */
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
   input  alu_fn_e     i_fn,
   input  logic [31:0] i_x,
   input  logic [31:0] i_y,
   output logic [31:0] o_out,
   output logic        o_eq
);

   assign o_eq = (i_x == i_y);

   always_comb begin
      case (i_fn)
         ADD:     o_out = i_x + i_y;
         SUB:     o_out = i_x - i_y;
         SLL:     o_out = i_x << i_y[4:0];
         SLT:     o_out = {31'b0, $signed(i_x) < $signed(i_y)};
         SLTU:    o_out = {31'b0, i_x < i_y};
         XOR:     o_out = i_x ^ i_y;
         SRL:     o_out = i_x >> i_y[4:0];
         SRA:     o_out = $unsigned($signed(i_x) >>> i_y[4:0]);
         OR:      o_out = i_x | i_y;
         AND:     o_out = i_x & i_y;
         EQ:      o_out = {31'b0, o_eq};
         default: o_out = '0;
      endcase
   end

   // Known function must never produce an unknown result
   always_comb begin
      if (!$isunknown(i_fn)) begin
         a_out_known: assert (!$isunknown(o_out));
      end
   end

endmodule

//--- hdl/rv_decode.sv
/* Instruction decoder: pulls the fields out of the fetched word, builds the
   immediate and picks the ALU function and operand sources */
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
   input  inst_u i_inst,
   output dec_t  o_dec
);

   always_comb begin
      o_dec         = '0;
      o_dec.opcode  = opcode_e'(i_inst.r.opcode);
      o_dec.rd      = i_inst.r.rd;
      o_dec.rs1     = i_inst.r.rs1;
      o_dec.rs2     = i_inst.r.rs2;
      o_dec.funct3  = i_inst.r.funct3;
      o_dec.alu_fn  = ADD;
      o_dec.sel_imm = 1'b1;
      o_dec.legal   = 1'b1;

      case (o_dec.opcode)
         ALU_R: begin
            o_dec.alu_fn  = alu_fn_e'({i_inst.r.funct7[5], i_inst.r.funct3});
            o_dec.sel_imm = 1'b0;
         end
         ALU_I, LOAD, JALR: begin
            o_dec.imm = {{20{i_inst.i.imm[11]}}, i_inst.i.imm};
            // Only immediate shifts carry funct7
            if (o_dec.opcode == ALU_I) begin
               o_dec.alu_fn = alu_fn_e'({(i_inst.i.funct3[1:0] == 2'b01) & i_inst.r.funct7[5],
                                         i_inst.i.funct3});
            end
         end
         STORE: begin
            o_dec.imm = {{20{i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
         end
         BRANCH: begin
            o_dec.imm = {{19{i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                         i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
            o_dec.sel_imm = 1'b0;
            case (i_inst.b.funct3[2:1])
               2'b10:   o_dec.alu_fn = SLT;
               2'b11:   o_dec.alu_fn = SLTU;
               default: o_dec.alu_fn = EQ;
            endcase
         end
         LUI, AUIPC: begin
            o_dec.imm    = {i_inst.u.imm_31_12, 12'b0};
            o_dec.sel_pc = (o_dec.opcode == AUIPC);
         end
         JAL: begin
            o_dec.imm = {{11{i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                         i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};
            o_dec.sel_pc = 1'b1;
         end
         default: o_dec.legal = 1'b0;
      endcase
   end

endmodule

//--- hdl/rv_core.sv
/* Multi-cycle RV32I core with a Wishbone classic master; the register file
   lives in RAM, one word per register at address rd * 4 */
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
   input  logic    clk,
   input  logic    i_rst_n,
   input  logic    i_run,
   input  logic    i_clear_fault,
   output wb_req_t o_bus,
   input  wb_rsp_t i_bus,
   output logic    o_running,
   output logic    o_fault,
   output logic    o_retire
);

   typedef enum logic [3:0] {
      S_IDLE, S_BOOT_SP, S_BOOT_WSP, S_BOOT_PC, S_FETCH, S_DECODE,
      S_RS1, S_RS2, S_MEM, S_WB, S_FAULT, S_DONE
   } state_e;

   state_e      state;
   state_e      after;
   state_e      wb_or_done;
   logic        gap;
   logic        req;
   logic        acked;
   logic        step;
   logic [15:0] pc;
   logic [15:0] pc4;
   logic [15:0] next_pc;
   inst_u       inst;
   dec_t        dec;
   logic [31:0] rs1_val;
   logic [31:0] rs2_val;
   logic [31:0] rd_val;
   logic [31:0] alu_x;
   logic [31:0] alu_y;
   logic [31:0] alu_out;
   logic        alu_eq;
   logic        taken;
   logic [31:0] ld_shift;
   logic [31:0] ld_val;
   logic [31:0] wb_dat;
   logic [1:0]  off;

   rv_decode u_decode (.i_inst(inst), .o_dec(dec));

   assign alu_x = dec.sel_pc ? {16'b0, pc} : rs1_val;
   assign alu_y = dec.sel_imm ? dec.imm : rs2_val;

   rv_alu u_alu (.i_fn(dec.alu_fn), .i_x(alu_x), .i_y(alu_y), .o_out(alu_out), .o_eq(alu_eq));

   // Stb drops for one cycle after every ack
   assign req   = (state inside {S_BOOT_SP, S_BOOT_WSP, S_BOOT_PC, S_FETCH,
                                 S_RS1, S_RS2, S_MEM, S_WB}) && !gap;
   assign acked = req && i_bus.ack;
   assign step  = acked || (state == S_DECODE);

   assign pc4      = pc + 16'd4;
   assign off      = alu_out[1:0];
   assign taken    = (dec.funct3[2] ? alu_out[0] : alu_eq) ^ dec.funct3[0];
   assign ld_shift = i_bus.dat >> {off, 3'b000};

   always_comb begin
      case (dec.funct3)
         3'b000:  ld_val = {{24{ld_shift[7]}}, ld_shift[7:0]};
         3'b001:  ld_val = {{16{ld_shift[15]}}, ld_shift[15:0]};
         3'b100:  ld_val = {24'b0, ld_shift[7:0]};
         3'b101:  ld_val = {16'b0, ld_shift[15:0]};
         default: ld_val = ld_shift;
      endcase

      case (dec.opcode)
         LOAD:      wb_dat = rd_val;
         LUI:       wb_dat = dec.imm;
         JAL, JALR: wb_dat = {16'b0, pc4};
         default:   wb_dat = alu_out;
      endcase

      case (dec.opcode)
         BRANCH:  next_pc = taken ? pc + dec.imm[15:0] : pc4;
         JAL:     next_pc = alu_out[15:0];
         JALR:    next_pc = alu_out[15:0] & 16'hfffe;
         default: next_pc = pc4;
      endcase
   end

   // State that follows the current step, S_DONE ends the instruction
   always_comb begin
      wb_or_done = (dec.rd != 5'd0) ? S_WB : S_DONE;
      case (state)
         S_BOOT_SP:  after = S_BOOT_WSP;
         S_BOOT_WSP: after = S_BOOT_PC;
         S_BOOT_PC:  after = S_FETCH;
         S_FETCH:    after = S_DECODE;
         S_DECODE: begin
            if (!dec.legal) after = S_FAULT;
            else if (dec.opcode inside {JAL, LUI, AUIPC}) after = wb_or_done;
            else after = S_RS1;
         end
         S_RS1: begin
            if (dec.opcode inside {ALU_R, STORE, BRANCH}) after = S_RS2;
            else if (dec.opcode == LOAD) after = S_MEM;
            else after = wb_or_done;
         end
         S_RS2: begin
            if (dec.opcode == STORE) after = S_MEM;
            else if (dec.opcode == BRANCH) after = S_DONE;
            else after = wb_or_done;
         end
         S_MEM:   after = (dec.opcode == LOAD) ? wb_or_done : S_DONE;
         default: after = S_DONE;
      endcase
   end

   always_comb begin
      o_bus     = '0;
      o_bus.cyc = req;
      o_bus.stb = req;
      o_bus.sel = 4'hf;
      case (state)
         S_BOOT_SP:  o_bus.adr = VEC_SP;
         S_BOOT_WSP: begin
            o_bus.adr = {9'b0, SP_INIT_REG, 2'b00};
            o_bus.we  = 1'b1;
            o_bus.dat = rd_val;
         end
         S_BOOT_PC:  o_bus.adr = VEC_RESET;
         S_FETCH:    o_bus.adr = pc;
         S_RS1:      o_bus.adr = {9'b0, dec.rs1, 2'b00};
         S_RS2:      o_bus.adr = {9'b0, dec.rs2, 2'b00};
         S_MEM: begin
            o_bus.adr = alu_out[15:0];
            if (dec.opcode == STORE) begin
               o_bus.we  = 1'b1;
               o_bus.dat = rs2_val << {off, 3'b000};
               case (dec.funct3[1:0])
                  2'b00:   o_bus.sel = 4'b0001 << off;
                  2'b01:   o_bus.sel = 4'b0011 << off;
                  default: o_bus.sel = 4'b1111;
               endcase
            end
         end
         S_WB: begin
            o_bus.adr = {9'b0, dec.rd, 2'b00};
            o_bus.we  = 1'b1;
            o_bus.dat = wb_dat;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state    <= S_IDLE;
         pc       <= '0;
         gap      <= 1'b0;
         o_retire <= 1'b0;
      end else begin
         gap      <= acked;
         o_retire <= 1'b0;
         case (state)
            S_IDLE:  if (i_run) state <= S_BOOT_SP;
            S_FAULT: if (i_clear_fault) state <= S_IDLE;
            S_DONE: begin
               // Run is only sampled at an instruction boundary
               pc       <= next_pc;
               o_retire <= 1'b1;
               state    <= i_run ? S_FETCH : S_IDLE;
            end
            default: begin
               if (step) begin
                  if (state == S_BOOT_PC) pc <= i_bus.dat[15:0];
                  state <= after;
               end
            end
         endcase
      end
   end

   // x0 reads as zero whatever word 0 holds
   always_ff @(posedge clk) begin
      if (acked) begin
         case (state)
            S_BOOT_SP: rd_val  <= i_bus.dat;
            S_FETCH:   inst    <= i_bus.dat;
            S_RS1:     rs1_val <= (dec.rs1 == 5'd0) ? '0 : i_bus.dat;
            S_RS2:     rs2_val <= (dec.rs2 == 5'd0) ? '0 : i_bus.dat;
            S_MEM:     rd_val  <= ld_val;
            default: ;
         endcase
      end
   end

   assign o_running = (state != S_IDLE) && (state != S_FAULT);
   assign o_fault   = (state == S_FAULT);

   a_adr_known: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_bus.cyc && o_bus.stb |-> !$isunknown(o_bus.adr));

   a_no_x0_write: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_bus.cyc && o_bus.stb && o_bus.we |-> o_bus.adr[15:2] != '0);

   // Request held steady until the slave acks
   a_req_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_bus.stb && !i_bus.ack |=> $stable(o_bus));

endmodule

//--- hdl/rv_ctrl.sv
/* Host register block: run control, status and retired count at the
   control base, everything else forwarded to RAM port B */
`timescale 1ns/1ps

module rv_ctrl import rv_pkg::*; (
   input  logic    clk,
   input  logic    i_rst_n,
   input  wb_req_t i_host,
   output wb_rsp_t o_host,
   output wb_req_t o_mem,
   input  wb_rsp_t i_mem,
   input  logic    i_running,
   input  logic    i_fault,
   input  logic    i_retire,
   output logic    o_run,
   output logic    o_clear_fault
);

   logic        is_reg;
   logic        reg_stb;
   logic        reg_ack;
   logic        run_wr;
   logic        restart;
   logic [15:0] offset;
   logic [31:0] reg_dat;
   logic [31:0] retired;

   assign is_reg  = (i_host.adr & HOST_CTRL_BASE) == HOST_CTRL_BASE;
   assign offset  = i_host.adr & ~HOST_CTRL_BASE;
   assign reg_stb = i_host.cyc && i_host.stb && is_reg && !reg_ack;
   assign run_wr  = reg_stb && i_host.we && i_host.sel[0] && (offset == REG_CTRL);
   // A fresh boot, either from stopped or out of a fault
   assign restart = run_wr && i_host.dat[0] && (!o_run || i_fault);

   // Memory path is purely combinational
   always_comb begin
      o_mem      = i_host;
      o_mem.cyc  = i_host.cyc && !is_reg;
      o_mem.stb  = i_host.stb && !is_reg;
      o_host.ack = is_reg ? reg_ack : i_mem.ack;
      o_host.dat = is_reg ? reg_dat : i_mem.dat;
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         reg_ack       <= 1'b0;
         o_run         <= 1'b0;
         o_clear_fault <= 1'b0;
         retired       <= '0;
      end else begin
         reg_ack       <= reg_stb;
         o_clear_fault <= run_wr && i_host.dat[0] && i_fault;
         if (run_wr) o_run <= i_host.dat[0];
         if (restart) retired <= '0;
         else if (i_retire) retired <= retired + 32'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_stb) begin
         case (offset)
            REG_CTRL:    reg_dat <= {31'b0, o_run};
            REG_STATUS:  reg_dat <= {30'b0, i_fault, i_running};
            REG_RETIRED: reg_dat <= retired;
            default:     reg_dat <= '0;
         endcase
      end
   end

   a_one_target: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(o_mem.cyc && o_mem.stb && reg_ack));

endmodule

//--- hdl/rv_mem.sv
/* Dual-port word RAM with two Wishbone classic slave ports and byte lanes;
   port A is the core, port B the host */
`timescale 1ns/1ps

module rv_mem import rv_pkg::*; (
   input  logic    clk,
   input  logic    i_rst_n,
   input  wb_req_t i_a,
   input  wb_req_t i_b,
   output wb_rsp_t o_a,
   output wb_rsp_t o_b
);

   logic [31:0] mem [MEM_WORDS];
   wb_req_t     req [2];
   logic [31:0] rdat [2];
   logic [1:0]  ack;

   assign req[0] = i_a;
   assign req[1] = i_b;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack <= '0;
      end else begin
         for (int p = 0; p < 2; p++) begin
            ack[p] <= req[p].cyc && req[p].stb && !ack[p];
         end
      end
   end

   // Port B first so that port A wins a same-word write
   always_ff @(posedge clk) begin
      for (int p = 1; p >= 0; p--) begin
         if (req[p].cyc && req[p].stb && !ack[p]) begin
            rdat[p] <= mem[req[p].adr[MEM_AW+1:2]];
            if (req[p].we) begin
               for (int l = 0; l < 4; l++) begin
                  if (req[p].sel[l]) begin
                     mem[req[p].adr[MEM_AW+1:2]][8*l +: 8] <= req[p].dat[8*l +: 8];
                  end
               end
            end
         end
      end
   end

   assign o_a = '{ack: ack[0], dat: rdat[0]};
   assign o_b = '{ack: ack[1], dat: rdat[1]};

endmodule

//--- hdl/rv_top.sv
/* Subsystem top: core and host control block sharing one dual-port RAM,
   host bus and run and fault status brought out */
`timescale 1ns/1ps

module rv_top import rv_pkg::*; (
   input  logic    clk,
   input  logic    i_rst_n,
   input  wb_req_t i_host,
   output wb_rsp_t o_host,
   output logic    o_running,
   output logic    o_fault
);

   wb_req_t core_req;
   wb_rsp_t core_rsp;
   wb_req_t mem_b_req;
   wb_rsp_t mem_b_rsp;
   logic    run;
   logic    clear_fault;
   logic    retire;

   rv_core u_core (
      .clk(clk), .i_rst_n(i_rst_n), .i_run(run), .i_clear_fault(clear_fault),
      .o_bus(core_req), .i_bus(core_rsp),
      .o_running(o_running), .o_fault(o_fault), .o_retire(retire)
   );

   rv_ctrl u_ctrl (
      .clk(clk), .i_rst_n(i_rst_n), .i_host(i_host), .o_host(o_host),
      .o_mem(mem_b_req), .i_mem(mem_b_rsp),
      .i_running(o_running), .i_fault(o_fault), .i_retire(retire),
      .o_run(run), .o_clear_fault(clear_fault)
   );

   rv_mem u_mem (
      .clk(clk), .i_rst_n(i_rst_n), .i_a(core_req), .i_b(mem_b_req),
      .o_a(core_rsp), .o_b(mem_b_rsp)
   );

endmodule

//--- verif/tb_programs.svh
/* Directed tests of the subsystem testbench: instruction encoders, an RV32I
   reference model and the test programs, included inside the testbench module */

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
   return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
   return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [11:0] imm);
   return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [12:0] imm);
   return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
                                       input logic [19:0] imm);
   return {imm, rd, op};
endfunction

function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// RV32I result rules, alt is funct7 bit 5
function automatic logic [31:0] alu_ref(input logic alt, input logic [2:0] f3,
                                        input logic [31:0] x, input logic [31:0] y);
   case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return {31'b0, $signed(x) < $signed(y)};
      3'd3:    return {31'b0, x < y};
      3'd4:    return x ^ y;
      3'd5:    return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6:    return x | y;
      default: return x & y;
   endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] x,
                                    input logic [31:0] y);
   case (f3)
      3'd0:    return x == y;
      3'd1:    return x != y;
      3'd4:    return $signed(x) < $signed(y);
      3'd5:    return $signed(x) >= $signed(y);
      3'd6:    return x < y;
      default: return x >= y;
   endcase
endfunction

// raw holds the bytes from the load address upward
function automatic logic [31:0] load_ref(input logic [2:0] f3, input logic [31:0] raw);
   case (f3)
      3'd0:    return {{24{raw[7]}}, raw[7:0]};
      3'd1:    return {{16{raw[15]}}, raw[15:0]};
      3'd4:    return {24'b0, raw[7:0]};
      3'd5:    return {16'b0, raw[15:0]};
      default: return raw;
   endcase
endfunction

task automatic begin_program();
   prog.delete();
   for (int r = 0; r < 32; r++) begin
      exp_set[r] = 1'b0;
   end
endtask

task automatic emit(input logic [31:0] word);
   prog.push_back(word);
endtask

function automatic logic [31:0] here();
   return {16'b0, PROG_BASE} + 32'(4 * prog.size());
endfunction

task automatic expect_reg(input logic [4:0] rd, input logic [31:0] v);
   exp_reg[rd] = v;
   exp_set[rd] = 1'b1;
endtask

// LUI plus ADDI, upper part rounded for the signed low part
task automatic load_imm(input logic [4:0] rd, input logic [31:0] v);
   logic [31:0] hi;
   hi = v + 32'h800;
   emit(u_type(LUI, rd, hi[31:12]));
   emit(i_type(ALU_I, 3'd0, rd, rd, v[11:0]));
   expect_reg(rd, v);
endtask

task automatic host_access();
   int          e0;
   logic [31:0] v;
   logic [31:0] w;
   logic [31:0] n;
   logic [31:0] r;
   logic [31:0] exp;
   logic [15:0] a;
   e0 = errors;
   check("o_running", {31'b0, running}, 32'h0);
   check("o_fault", {31'b0, fault}, 32'h0);
   host_read(HOST_CTRL_BASE | REG_STATUS, v);
   check("STATUS", v, 32'h0);
   host_read(HOST_CTRL_BASE | REG_CTRL, v);
   check("CTRL", v, 32'h0);
   host_read(HOST_CTRL_BASE | REG_RETIRED, v);
   check("RETIRED", v, 32'h0);
   for (int k = 0; k < 6; k++) begin
      r = rand_bits(10);
      a = {4'b0, r[9:0], 2'b00};
      w = rand_bits(32);
      host_write(a, w, 4'hf);
      host_read(a, v);
      check($sformatf("ram[%h]", a), v, w);
      r = rand_bits(4);
      n = rand_bits(32);
      host_write(a, n, r[3:0]);
      for (int l = 0; l < 4; l++) begin
         exp[8*l +: 8] = r[l] ? n[8*l +: 8] : w[8*l +: 8];
      end
      host_read(a, v);
      check($sformatf("ram[%h] merged", a), v, exp);
   end
   report_test("host access and reset state", e0);
endtask

task automatic alu_program();
   int          e0;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] imm;
   logic [31:0] pc;
   logic [2:0]  f3;
   logic        alt;
   logic [4:0]  rd;
   e0 = errors;
   begin_program();
   a = rand_bits(32);
   b = rand_bits(32);
   load_imm(5'd5, a);
   load_imm(5'd6, b);
   rd = 5'd7;
   // Eight funct3 codes, then SUB and SRA
   for (int k = 0; k < 10; k++) begin
      f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
      alt = (k >= 8);
      emit(r_type({1'b0, alt, 5'b0}, f3, rd, 5'd5, 5'd6));
      expect_reg(rd, alu_ref(alt, f3, a, b));
      rd++;
   end
   for (int k = 0; k < 9; k++) begin
      f3  = (k < 8) ? 3'(k) : 3'd5;
      alt = (k == 8);
      imm = rand_bits(12);
      if (f3 == 3'd1 || f3 == 3'd5) begin
         imm = {20'b0, 1'b0, alt, 5'b0, imm[4:0]};
      end else begin
         imm = {{20{imm[11]}}, imm[11:0]};
      end
      emit(i_type(ALU_I, f3, rd, 5'd5, imm[11:0]));
      expect_reg(rd, alu_ref(alt, f3, a, imm));
      rd++;
   end
   imm = rand_bits(20);
   emit(u_type(LUI, 5'd26, imm[19:0]));
   expect_reg(5'd26, {imm[19:0], 12'b0});
   imm = rand_bits(20);
   pc  = here();
   emit(u_type(AUIPC, 5'd27, imm[19:0]));
   expect_reg(5'd27, pc + {imm[19:0], 12'b0});
   emit(r_type(7'd0, 3'd0, 5'd0, 5'd5, 5'd6));
   expect_reg(5'd0, 32'h0);
   run_program(32'h0000_0ff0);
   compare_regs();
   report_test("ALU and upper immediates", e0);
endtask

task automatic load_store_program();
   int          e0;
   int          o;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] v;
   logic [7:0]  img [12];
   logic [2:0]  ld_f3 [13];
   int          ld_off [13];
   e0 = errors;
   ld_f3  = '{3'd0, 3'd0, 3'd0, 3'd0, 3'd4, 3'd4, 3'd4, 3'd4, 3'd1, 3'd1, 3'd5, 3'd5, 3'd2};
   ld_off = '{0, 1, 2, 3, 0, 1, 2, 3, 4, 6, 4, 6, 8};
   begin_program();
   a = rand_bits(32);
   b = rand_bits(32);
   load_imm(5'd5, {16'b0, DATA_BASE});
   load_imm(5'd6, a);
   load_imm(5'd7, b);
   for (int k = 0; k < 4; k++) begin
      v = k[0] ? b : a;
      emit(s_type(3'd0, 5'd5, k[0] ? 5'd7 : 5'd6, 12'(k)));
      img[k] = v[7:0];
   end
   for (int k = 0; k < 2; k++) begin
      v = k[0] ? b : a;
      emit(s_type(3'd1, 5'd5, k[0] ? 5'd7 : 5'd6, 12'(4 + 2 * k)));
      img[4 + 2 * k] = v[7:0];
      img[5 + 2 * k] = v[15:8];
   end
   emit(s_type(3'd2, 5'd5, 5'd6, 12'd8));
   for (int l = 0; l < 4; l++) begin
      img[8 + l] = a[8*l +: 8];
   end
   for (int k = 0; k < 13; k++) begin
      o = ld_off[k];
      emit(i_type(LOAD, ld_f3[k], 5'(10 + k), 5'd5, 12'(o)));
      expect_reg(5'(10 + k), load_ref(ld_f3[k], {img[o+3], img[o+2], img[o+1], img[o]}));
   end
   run_program(32'h0000_0ff0);
   compare_regs();
   for (int w = 0; w < 3; w++) begin
      host_read(DATA_BASE + 16'(4 * w), v);
      check($sformatf("ram[%h]", DATA_BASE + 16'(4 * w)), v,
            {img[4*w+3], img[4*w+2], img[4*w+1], img[4*w]});
   end
   report_test("loads and stores", e0);
endtask

task automatic control_flow_program();
   int          e0;
   logic [31:0] n;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] p;
   logic [2:0]  f3;
   e0 = errors;
   begin_program();
   n = 32'd3 + rand_bits(3);
   a = rand_bits(32);
   // Flipped top bit makes signed and unsigned order disagree
   b = a ^ 32'h8000_0001;
   emit(i_type(ALU_I, 3'd0, 5'd5, 5'd0, n[11:0]));
   emit(i_type(ALU_I, 3'd0, 5'd6, 5'd6, 12'd3));
   emit(i_type(ALU_I, 3'd0, 5'd5, 5'd5, 12'hfff));
   emit(b_type(3'd1, 5'd5, 5'd0, 13'h1ff8));
   expect_reg(5'd5, 32'h0);
   expect_reg(5'd6, 32'd3 * n);
   load_imm(5'd7, a);
   load_imm(5'd8, b);
   for (int k = 0; k < 8; k++) begin
      f3 = 3'(4 + (k >> 1));
      emit(b_type(f3, k[0] ? 5'd8 : 5'd7, k[0] ? 5'd7 : 5'd8, 13'd8));
      emit(i_type(ALU_I, 3'd0, 5'(10 + k), 5'd0, 12'd1));
      expect_reg(5'(10 + k), branch_ref(f3, k[0] ? b : a, k[0] ? a : b) ? 32'h0 : 32'h1);
   end
   p = here();
   emit(j_type(5'd18, 21'd8));
   emit(i_type(ALU_I, 3'd0, 5'd19, 5'd0, 12'd1));
   expect_reg(5'd18, p + 32'd4);
   expect_reg(5'd19, 32'h0);
   p = here();
   emit(u_type(AUIPC, 5'd20, 20'h0));
   emit(i_type(JALR, 3'd0, 5'd21, 5'd20, 12'd12));
   emit(i_type(ALU_I, 3'd0, 5'd22, 5'd0, 12'd1));
   expect_reg(5'd20, p);
   expect_reg(5'd21, p + 32'd8);
   expect_reg(5'd22, 32'h0);
   run_program(32'h0000_0ff0);
   compare_regs();
   report_test("control flow", e0);
endtask

task automatic boot_and_fault();
   int          e0;
   int          n;
   logic [31:0] sp;
   logic [31:0] a;
   logic [31:0] v;
   e0 = errors;
   begin_program();
   sp = rand_bits(32);
   a  = rand_bits(32);
   load_imm(5'd5, a);
   emit(i_type(ALU_I, 3'd0, 5'd6, 5'd5, 12'd7));
   emit(r_type(7'd0, 3'd4, 5'd7, 5'd5, 5'd6));
   expect_reg(5'd6, a + 32'd7);
   expect_reg(5'd7, a ^ (a + 32'd7));
   expect_reg(5'd2, sp);
   n = prog.size();
   run_program(sp);
   for (int pass = 0; pass < 2; pass++) begin
      host_read(HOST_CTRL_BASE | REG_STATUS, v);
      check("STATUS", v, 32'h2);
      host_read(HOST_CTRL_BASE | REG_CTRL, v);
      check("CTRL", v, 32'h1);
      host_read(HOST_CTRL_BASE | REG_RETIRED, v);
      check("RETIRED", v, 32'(n));
      compare_regs();
      // Fault must outlast all the host reads above
      check("o_fault", {31'b0, fault}, 32'h1);
      // Wipe the results so the rerun must rebuild them
      for (int r = 2; r < 8; r++) begin
         host_write(16'(4 * r), 32'h0, 4'hf);
      end
      if (pass == 0) begin
         start_and_wait();
      end
   end
   report_test("boot, fault and retired count", e0);
endtask

//--- verif/tb_rv_top.sv
/* Testbench for the RV32I subsystem: drives the host bus, loads and runs
   small programs and compares register and memory words with a model */
`timescale 1ns/1ps

module tb_rv_top import rv_pkg::*; ();

   localparam logic [15:0] PROG_BASE = 16'h0100;
   localparam logic [15:0] DATA_BASE = 16'h0400;
   // Cycle budgets of the five tests in order
   localparam int BUDGET_CYCLES = 600 + 2500 + 2500 + 2500 + 5000;

   logic    clk;
   logic    rst_n;
   wb_req_t host_req;
   wb_rsp_t host_rsp;
   logic    running;
   logic    fault;

   int          errors;
   int          checks;
   int          tests;
   logic [31:0] lfsr;
   logic [31:0] prog [$];
   logic [31:0] exp_reg [32];
   bit          exp_set [32];

   rv_top DUT (
      .clk(clk), .i_rst_n(rst_n), .i_host(host_req), .o_host(host_rsp),
      .o_running(running), .o_fault(fault)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
      end
      return v;
   endfunction

   // Called on a falling edge, returns on a falling edge
   task automatic host_write(input logic [15:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
      host_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat, sel: sel};
      @(negedge clk);
      while (!host_rsp.ack) begin
         @(negedge clk);
      end
      host_req = '0;
      @(negedge clk);
   endtask

   task automatic host_read(input logic [15:0] adr, output logic [31:0] dat);
      host_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0, sel: 4'hf};
      @(negedge clk);
      while (!host_rsp.ack) begin
         @(negedge clk);
      end
      dat = host_rsp.dat;
      host_req = '0;
      @(negedge clk);
   endtask

   // Every program ends in a fault after a spell of running
   task automatic wait_fault();
      logic seen_run;
      seen_run = 1'b0;
      while (fault) begin
         @(negedge clk);
      end
      while (!fault) begin
         seen_run = seen_run | running;
         @(negedge clk);
      end
      check("o_running during run", {31'b0, seen_run}, 32'h1);
      check("o_running at fault", {31'b0, running}, 32'h0);
   endtask

   task automatic start_and_wait();
      host_write(HOST_CTRL_BASE | REG_CTRL, 32'h1, 4'hf);
      wait_fault();
   endtask

   // Vectors, cleared register words and the program, then one run
   task automatic run_program(input logic [31:0] sp);
      prog.push_back(32'h0);
      host_write(VEC_SP, sp, 4'hf);
      host_write(VEC_RESET, {16'b0, PROG_BASE}, 4'hf);
      for (int r = 0; r < 32; r++) begin
         host_write(16'(4 * r), 32'h0, 4'hf);
      end
      for (int k = 0; k < prog.size(); k++) begin
         host_write(PROG_BASE + 16'(4 * k), prog[k], 4'hf);
      end
      start_and_wait();
   endtask

   task automatic compare_regs();
      logic [31:0] v;
      for (int r = 0; r < 32; r++) begin
         if (exp_set[r]) begin
            host_read(16'(4 * r), v);
            check($sformatf("x%0d", r), v, exp_reg[r]);
         end
      end
   endtask

   task automatic report_test(input string name, input int e0);
      tests++;
      $display("test %0d %s finished with %0d errors", tests, name, errors - e0);
   endtask

   `include "tb_programs.svh"

   initial begin
      repeat (BUDGET_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, a test did not finish", BUDGET_CYCLES);
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      host_req = '0;
      rst_n    = 1'b0;
      errors   = 0;
      checks   = 0;
      tests    = 0;
      lfsr     = 32'h282ac073;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      host_access();
      alu_program();
      load_store_program();
      control_flow_program();
      boot_and_fault();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- tb.f
+incdir+verif
hdl/rv_pkg.sv
hdl/rv_alu.sv
hdl/rv_decode.sv
hdl/rv_core.sv
hdl/rv_ctrl.sv
hdl/rv_mem.sv
hdl/rv_top.sv
verif/tb_rv_top.sv

//--- Makefile
# Verilator build and run of the RV32I subsystem testbench

.PHONY: all lint clean

all: obj_dir/Vtb_rv_top
	./obj_dir/Vtb_rv_top | tee /dev/stderr | grep -q "Simulation PASSED"

obj_dir/Vtb_rv_top: tb.f hdl/*.sv verif/*.sv verif/*.svh
	verilator --binary --timing --assert -f tb.f --top-module tb_rv_top -o Vtb_rv_top

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module rv_top

clean:
	rm -rf obj_dir
